// ==== basic_organ.f ====
src/organ_pkg.sv
src/organ_input_decode.sv
src/organ_tone_gen.sv
src/speed_reg.sv
src/organ_output_stage.sv
src/basic_organ_top.sv
testbench/tb_basic_organ.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the organ testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_basic_organ \
  -f basic_organ.f \
  --Mdir "$BUILD_DIR" -o tb_basic_organ
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_basic_organ" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== testbench/tb_basic_organ.sv ====
`timescale 1ns/1ps

module tb_basic_organ
  import organ_pkg::*;
;

  localparam int TB_CLK_HZ    = 50_000;
  localparam int CLK_PERIOD   = 20;
  localparam int EVENT_CLOCKS = 5000;
  localparam int STEP         = 100;
  localparam int BASE_COUNT   = 12499;
  localparam int SYNC_DELAY   = 2;
  // Sync, pulse and display pipeline after a key release
  localparam int KEY_SETTLE   = 8;

  logic          CLK_50M;
  logic          arst_n;
  logic [2:0]    key;
  logic [3:0]    sw;
  seg_t          hex0;
  seg_t          hex1;
  seg_t          hex2;
  seg_t          hex3;
  seg_t          hex4;
  seg_t          hex5;
  audio_sample_t audio_sample;

  int            error_count;
  int            timeout_count;
  int            check_count;
  logic [31:0]   lfsr_state;
  sample_count_t exp_count;

  basic_organ_top #(
    .CLK_HZ (TB_CLK_HZ)
  ) dut (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .key          (key),
    .sw           (sw),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5),
    .audio_sample (audio_sample)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;
  end

  // ==============================
  // Reference models
  // ==============================

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    else
      return s >> 1;
  endfunction

  task automatic take_random_bits(input int nbits, output int value);
    value = 0;
    for (int i = 0; i < nbits; i++)
    begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Note frequencies in centihertz, C4 up to C5
  function automatic int expected_half_period(input int n);
    int centi_hz [8];
    centi_hz = '{26163, 29366, 32963, 34923, 39200, 44000, 49388, 52325};
    return (TB_CLK_HZ * 100) / (2 * centi_hz[n]);
  endfunction

  function automatic seg_t expected_seg(input int digit);
    // Lit segments g..a, active high
    logic [6:0] lit [16];
    lit = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
            7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
    return ~lit[digit];
  endfunction

  function automatic bit display_matches(input sample_count_t value);
    seg_t shown [num_digits];
    int   digit;
    bit   ok;
    shown = '{hex0, hex1, hex2, hex3, hex4, hex5};
    ok = 1'b1;
    for (int i = 0; i < num_digits; i++)
    begin
      digit = (i < 4) ? int'((value >> (4 * i)) & 16'hF) : 0;
      if (shown[i] !== expected_seg(digit))
        ok = 1'b0;
    end
    return ok;
  endfunction

  function automatic sample_count_t count_after(input sample_count_t start, input int which,
                                                input int k);
    if (which == 0)
      return start + sample_count_t'(k * STEP);
    else
      return start - sample_count_t'(k * STEP);
  endfunction

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_audio(input audio_sample_t got, input audio_sample_t exp,
                             input string what);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("[ERROR] %0t: %s audio_sample %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_tone_level(input audio_sample_t got, input string what);
    check_count++;
    if (got !== 8'h7F && got !== 8'h80)
    begin
      error_count++;
      $display("[ERROR] %0t: %s audio_sample %h is not a tone level", $time, what, got);
    end
  endtask

  task automatic check_seg(input seg_t got, input seg_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("[ERROR] %0t: %s segments %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Within one clock of the expected spacing
  task automatic check_half_period(input half_period_t got, input half_period_t exp,
                                   input string what);
    check_count++;
    if (got + 1 < exp || got > exp + 1)
    begin
      error_count++;
      $display("[ERROR] %0t: %s spacing %0d clocks, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_display(input sample_count_t exp, input string what);
    check_count++;
    if (!display_matches(exp))
    begin
      error_count++;
      $display("[ERROR] %0t: %s display does not show %h", $time, what, exp);
    end
  endtask

  // ==============================
  // Helpers
  // ==============================
  task automatic apply_reset();
    arst_n = 1'b0;
    repeat (3) @(negedge CLK_50M);
    arst_n = 1'b1;
  endtask

  task automatic wait_audio_toggle(input int limit, output int cycles, output bit ok);
    audio_sample_t prev;
    prev   = audio_sample;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < limit)
    begin
      @(negedge CLK_50M);
      cycles++;
      check_tone_level(audio_sample, "tone");
      if (audio_sample !== prev)
        ok = 1'b1;
    end
    if (!ok)
    begin
      timeout_count++;
      $display("Timeout: audio_sample did not toggle within %0d cycles", limit);
    end
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic test_reset_state();
    seg_t shown [num_digits];
    int   digit;
    repeat (2) @(negedge CLK_50M);
    check_audio(audio_sample, '0, "after reset");
    shown = '{hex0, hex1, hex2, hex3, hex4, hex5};
    // 12499 is 16'h30D3
    for (int i = 0; i < num_digits; i++)
    begin
      digit = (i < 4) ? ((BASE_COUNT >> (4 * i)) & 15) : 0;
      check_seg(shown[i], expected_seg(digit), "after reset");
    end
  endtask

  task automatic test_note_tones();
    int order [8];
    int j;
    int tmp;
    int hp;
    int spacing;
    bit ok;
    for (int i = 0; i < 8; i++)
      order[i] = i;
    // Shuffle the note order
    for (int i = 7; i > 0; i--)
    begin
      take_random_bits(4, j);
      j = j % (i + 1);
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int n = 0; n < 8; n++)
    begin
      hp = expected_half_period(order[n]);
      sw = {note_t'(order[n]), 1'b1};
      repeat (SYNC_DELAY + 2) @(negedge CLK_50M);
      // First half period after a note change is partial
      wait_audio_toggle(2 * hp + 8, spacing, ok);
      for (int t = 0; t < 3; t++)
      begin
        wait_audio_toggle(2 * hp + 8, spacing, ok);
        if (ok)
          check_half_period(half_period_t'(spacing), half_period_t'(hp), "note");
      end
    end
  endtask

  task automatic test_mute();
    int n;
    int hp;
    take_random_bits(3, n);
    hp = expected_half_period(n);
    sw = {note_t'(n), 1'b0};
    repeat (SYNC_DELAY + 2) @(negedge CLK_50M);
    for (int i = 0; i < 2 * hp; i++)
    begin
      @(negedge CLK_50M);
      check_audio(audio_sample, '0, "muted");
    end
  endtask

  // which 0 holds the speed-up key, 1 the slow-down key
  task automatic test_speed_key(input int which);
    int            periods;
    int            k;
    bit            found;
    sample_count_t start;
    take_random_bits(3, periods);
    periods = periods + 1;
    start = exp_count;
    key[which] = 1'b0;
    repeat (periods * EVENT_CLOCKS) @(negedge CLK_50M);
    key[which] = 1'b1;
    repeat (KEY_SETTLE) @(negedge CLK_50M);
    found = 1'b0;
    k = periods;
    for (int d = -1; d <= 1; d++)
    begin
      if (!found && display_matches(count_after(start, which, periods + d)))
      begin
        found = 1'b1;
        k = periods + d;
      end
    end
    exp_count = count_after(start, which, k);
    check_display(exp_count, (which == 0) ? "speed-up key" : "slow-down key");
  endtask

  task automatic test_speed_reset();
    int waited;
    bit done;
    key[2] = 1'b0;
    repeat (SYNC_DELAY) @(negedge CLK_50M);
    waited = 0;
    done   = 1'b0;
    while (!done && waited < 8)
    begin
      @(negedge CLK_50M);
      waited++;
      done = display_matches(sample_count_t'(BASE_COUNT));
    end
    if (!done)
    begin
      timeout_count++;
      $display("Timeout: display did not return to the default count within 8 cycles");
    end
    key[2] = 1'b1;
    exp_count = sample_count_t'(BASE_COUNT);
    check_display(exp_count, "speed reset");
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial
  begin
    error_count   = 0;
    timeout_count = 0;
    check_count   = 0;
    lfsr_state    = 32'h2df3;
    arst_n        = 1'b0;
    key           = 3'b111;
    sw            = 4'h0;
    exp_count     = sample_count_t'(BASE_COUNT);

    apply_reset();
    test_reset_state();
    test_note_tones();
    test_mute();
    test_speed_key(0);
    test_speed_reset();
    test_speed_key(1);
    test_speed_reset();

    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== src/basic_organ_top.sv ====
`timescale 1ns/1ps

module basic_organ_top
  import organ_pkg::*;
#(
  parameter int CLK_HZ               = 50_000_000,
  parameter int TICK_HZ              = 1000,
  parameter int EVENTS_PER_SEC       = 10,
  parameter int SPEED_STEP           = 100,
  parameter int DEFAULT_SAMPLE_COUNT = 12499
)
(
  input  logic          CLK_50M,
  input  logic          arst_n,
  input  logic [2:0]    key,
  input  logic [3:0]    sw,
  output seg_t          hex0,
  output seg_t          hex1,
  output seg_t          hex2,
  output seg_t          hex3,
  output seg_t          hex4,
  output seg_t          hex5,
  output audio_sample_t audio_sample
);

  note_t         note;
  logic          audio_en;
  logic          up_pulse;
  logic          down_pulse;
  logic          reset_pulse;
  logic          tone;
  sample_count_t sample_count;

  // ==============================
  // Input decode
  // ==============================
  organ_input_decode #(
    .CLK_HZ         (CLK_HZ),
    .TICK_HZ        (TICK_HZ),
    .EVENTS_PER_SEC (EVENTS_PER_SEC)
  ) u_input_decode (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .key         (key),
    .sw          (sw),
    .note        (note),
    .audio_en    (audio_en),
    .up_pulse    (up_pulse),
    .down_pulse  (down_pulse),
    .reset_pulse (reset_pulse)
  );

  // ==============================
  // Tone and speed
  // ==============================
  organ_tone_gen #(
    .CLK_HZ (CLK_HZ)
  ) u_tone_gen (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .note    (note),
    .tone    (tone)
  );

  speed_reg #(
    .SPEED_STEP           (SPEED_STEP),
    .DEFAULT_SAMPLE_COUNT (DEFAULT_SAMPLE_COUNT)
  ) u_speed_reg (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .up_pulse     (up_pulse),
    .down_pulse   (down_pulse),
    .reset_pulse  (reset_pulse),
    .sample_count (sample_count)
  );

  // Output stage
  organ_output_stage u_output_stage (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .tone         (tone),
    .audio_en     (audio_en),
    .sample_count (sample_count),
    .audio_sample (audio_sample),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

endmodule

// ==== src/organ_output_stage.sv ====
`timescale 1ns/1ps

module organ_output_stage
  import organ_pkg::*;
(
  input  logic          CLK_50M,
  input  logic          arst_n,
  input  logic          tone,
  input  logic          audio_en,
  input  sample_count_t sample_count,
  output audio_sample_t audio_sample,
  output seg_t          hex0,
  output seg_t          hex1,
  output seg_t          hex2,
  output seg_t          hex3,
  output seg_t          hex4,
  output seg_t          hex5
);

  display_word_u disp;
  seg_t          hex_q [num_digits];

  // ==============================
  // Audio sample
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      audio_sample <= '0;
    else if (!audio_en)
      audio_sample <= '0;
    else if (tone)
      audio_sample <= AUDIO_HIGH;
    else
      audio_sample <= AUDIO_LOW;
  end

  // ==============================
  // Seven-segment digits
  // ==============================

  // Count is 16 bits, top two digits read as zero
  always_comb
  begin
    disp.value = {8'h00, sample_count};
  end

  always_ff @(posedge CLK_50M)
  begin
    for (int i = 0; i < num_digits; i++)
    begin
      hex_q[i] <= hex_to_seg(disp.digit[i]);
    end
  end

  assign hex0 = hex_q[0];
  assign hex1 = hex_q[1];
  assign hex2 = hex_q[2];
  assign hex3 = hex_q[3];
  assign hex4 = hex_q[4];
  assign hex5 = hex_q[5];

  a_mute : assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (!audio_en ##1 !audio_en) |=> (audio_sample == '0));

endmodule

// ==== src/speed_reg.sv ====
`timescale 1ns/1ps

module speed_reg
  import organ_pkg::*;
#(
  parameter int SPEED_STEP           = 100,
  parameter int DEFAULT_SAMPLE_COUNT = 12499
)
(
  input  logic          CLK_50M,
  input  logic          arst_n,
  input  logic          up_pulse,
  input  logic          down_pulse,
  input  logic          reset_pulse,
  output sample_count_t sample_count
);

  speed_t speed;

  // Signed offset; up and down together cancel
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      speed <= '0;
    else if (reset_pulse)
      speed <= '0;
    else
    begin
      case ({up_pulse, down_pulse})
        2'b10:   speed <= speed + speed_t'(SPEED_STEP);
        2'b01:   speed <= speed - speed_t'(SPEED_STEP);
        default: speed <= speed;
      endcase
    end
  end

  // ==============================
  // Sampling count
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      sample_count <= sample_count_t'(DEFAULT_SAMPLE_COUNT);
    else
      sample_count <= sample_count_t'(DEFAULT_SAMPLE_COUNT) + sample_count_t'(speed);
  end

  a_reset_clears : assert property (@(posedge CLK_50M) disable iff (!arst_n)
    reset_pulse |=> (speed == '0));

endmodule

// ==== src/organ_tone_gen.sv ====
`timescale 1ns/1ps

module organ_tone_gen
  import organ_pkg::*;
#(
  parameter int CLK_HZ = 50_000_000
)
(
  input  logic  CLK_50M,
  input  logic  arst_n,
  input  note_t note,
  output logic  tone
);

  half_period_t hp_table [8];
  half_period_t half_period;
  half_period_t cnt;
  note_t        note_q;

  // Half periods are constants of CLK_HZ
  for (genvar i = 0; i < 8; i++)
  begin : g_hp
    assign hp_table[i] = note_half_period(note_t'(i), CLK_HZ);
  end

  assign half_period = hp_table[note_q];

  // ==============================
  // Note divider
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      note_q <= NOTE_C4;
      cnt    <= '0;
      tone   <= 1'b0;
    end
    else if (note != note_q)
    begin
      // New note, start the period over
      note_q <= note;
      cnt    <= '0;
    end
    else if (cnt == half_period - 1'b1)
    begin
      cnt  <= '0;
      tone <= ~tone;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

  a_cnt_range : assert property (@(posedge CLK_50M) disable iff (!arst_n)
    cnt < half_period);

endmodule

// ==== src/organ_input_decode.sv ====
`timescale 1ns/1ps

module organ_input_decode
  import organ_pkg::*;
#(
  parameter int CLK_HZ         = 50_000_000,
  parameter int TICK_HZ        = 1000,
  parameter int EVENTS_PER_SEC = 10
)
(
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  logic [2:0] key,
  input  logic [3:0] sw,
  output note_t      note,
  output logic       audio_en,
  output logic       up_pulse,
  output logic       down_pulse,
  output logic       reset_pulse
);

  localparam int TICK_DIV    = CLK_HZ / TICK_HZ;
  localparam int EVENT_TICKS = TICK_HZ / EVENTS_PER_SEC;
  localparam int TICK_W      = ($clog2(TICK_DIV) > 0) ? $clog2(TICK_DIV) : 1;
  localparam int EVENT_W     = ($clog2(EVENT_TICKS) > 0) ? $clog2(EVENT_TICKS) : 1;

  logic [2:0]         key_s1;
  logic [2:0]         key_s2;
  logic [3:0]         sw_s1;
  logic [3:0]         sw_s2;
  logic [2:0]         key_held;
  logic [TICK_W-1:0]  tick_cnt;
  logic [EVENT_W-1:0] event_cnt;
  logic               tick;
  logic               event_end;

  // ==============================
  // Two-flop synchronizers
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // Keys idle high
      key_s1 <= 3'b111;
      key_s2 <= 3'b111;
      sw_s1  <= '0;
      sw_s2  <= '0;
    end
    else
    begin
      key_s1 <= key;
      key_s2 <= key_s1;
      sw_s1  <= sw;
      sw_s2  <= sw_s1;
    end
  end

  assign key_held = ~key_s2;
  assign note     = note_t'(sw_s2[3:1]);
  assign audio_en = sw_s2[0];

  // ==============================
  // Tick and event period
  // ==============================
  assign tick      = (tick_cnt == TICK_W'(TICK_DIV - 1));
  assign event_end = tick && (event_cnt == EVENT_W'(EVENT_TICKS - 1));

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tick_cnt  <= '0;
      event_cnt <= '0;
    end
    else
    begin
      if (tick)
        tick_cnt <= '0;
      else
        tick_cnt <= tick_cnt + 1'b1;

      if (event_end)
        event_cnt <= '0;
      else if (tick)
        event_cnt <= event_cnt + 1'b1;
    end
  end

  // One pulse per event period while a speed key is held
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      up_pulse   <= 1'b0;
      down_pulse <= 1'b0;
    end
    else
    begin
      up_pulse   <= event_end && key_held[0];
      down_pulse <= event_end && key_held[1];
    end
  end

  // Speed reset is a plain level
  assign reset_pulse = key_held[2];

  a_up_single : assert property (@(posedge CLK_50M) disable iff (!arst_n)
    up_pulse |=> !up_pulse);

endmodule

// ==== src/organ_pkg.sv ====
package organ_pkg;

  // ==============================
  // Basic types
  // ==============================
  typedef logic [2:0]         note_t;
  typedef logic [31:0]        half_period_t;
  typedef logic signed [15:0] speed_t;
  typedef logic [15:0]        sample_count_t;
  typedef logic signed [7:0]  audio_sample_t;
  // Active low, bit 0 is segment a
  typedef logic [6:0]         seg_t;

  localparam int num_digits = 6;

  // Note codes, C4 up to C5
  localparam note_t NOTE_C4 = 3'd0;
  localparam note_t NOTE_D4 = 3'd1;
  localparam note_t NOTE_E4 = 3'd2;
  localparam note_t NOTE_F4 = 3'd3;
  localparam note_t NOTE_G4 = 3'd4;
  localparam note_t NOTE_A4 = 3'd5;
  localparam note_t NOTE_B4 = 3'd6;
  localparam note_t NOTE_C5 = 3'd7;

  // Signed full-scale levels for the square wave
  localparam audio_sample_t AUDIO_HIGH = 8'h7F;
  localparam audio_sample_t AUDIO_LOW  = 8'h80;

  // Display word, seen as one number or as six hex digits
  typedef union packed {
    logic [num_digits*4-1:0]       value;
    logic [num_digits-1:0][3:0]    digit;
  } display_word_u;

  // ==============================
  // Functions
  // ==============================

  // Clocks per half tone period; note table in centihertz
  function automatic half_period_t note_half_period(input note_t n,
                                                   input longint unsigned clk_hz);
    longint unsigned centi_hz;
    case (n)
      NOTE_C4: centi_hz = 26163;
      NOTE_D4: centi_hz = 29366;
      NOTE_E4: centi_hz = 32963;
      NOTE_F4: centi_hz = 34923;
      NOTE_G4: centi_hz = 39200;
      NOTE_A4: centi_hz = 44000;
      NOTE_B4: centi_hz = 49388;
      NOTE_C5: centi_hz = 52325;
      default: centi_hz = 26163;
    endcase
    return half_period_t'((clk_hz * 100) / (2 * centi_hz));
  endfunction

  function automatic seg_t hex_to_seg(input logic [3:0] d);
    case (d)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

endpackage
